//--- flist.f
source/cache_cfg_pkg.sv
source/cache_req_pkg.sv
source/way_select.sv
source/cache_arrays.sv
source/mem_port.sv
source/cache_ctrl_fsm.sv
source/cache_top.sv
verification/tb_mem_model.sv
verification/tb_cache_top.sv

//--- source/cache_arrays.sv
`timescale 1ns/1ps

module cache_arrays (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      cmd_valid_i,
    input  cache_req_pkg::array_cmd_t cmd_i,
    output cache_cfg_pkg::tag_t       [cache_cfg_pkg::num_ways-1:0] tags_o,
    output cache_cfg_pkg::way_vec_t   valid_o,
    output cache_cfg_pkg::line_t      [cache_cfg_pkg::num_ways-1:0] lines_o,
    output cache_cfg_pkg::way_vec_t   victim_way_o
);

    import cache_cfg_pkg::*;

    // per-set storage
    tag_t     [num_ways-1:0] tag_q  [num_sets];
    line_t    [num_ways-1:0] data_q [num_sets];
    way_vec_t                valid_q [num_sets];
    // round-robin pointer, one bit per set for two ways
    logic     [num_sets-1:0] rr_q;

    logic rd_en, wr_en;

    assign rd_en = cmd_valid_i && !cmd_i.we;
    assign wr_en = cmd_valid_i && cmd_i.we;

    // ------------------------------------------------
    // control state: valid bits and replacement
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q      <= '{default: '0};
            rr_q         <= '0;
            valid_o      <= '0;
            victim_way_o <= '0;
        end else if (rd_en) begin
            valid_o      <= valid_q[cmd_i.index];
            victim_way_o <= way_vec_t'(1) << rr_q[cmd_i.index];
        end else if (wr_en && cmd_i.fill) begin
            // a fill validates the way and moves the pointer on
            valid_q[cmd_i.index] <= valid_q[cmd_i.index] | cmd_i.way;
            rr_q[cmd_i.index]    <= ~rr_q[cmd_i.index];
        end
    end

    // ------------------------------------------------
    // tags and data
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            tags_o  <= tag_q[cmd_i.index];
            lines_o <= data_q[cmd_i.index];
        end
        if (wr_en) begin
            for (int unsigned w = 0; w < num_ways; w++) begin
                if (cmd_i.way[w]) begin
                    if (cmd_i.fill) begin
                        tag_q[cmd_i.index][w] <= cmd_i.tag;
                    end
                    // fill writes every byte, a store only the enabled ones
                    for (int unsigned wd = 0; wd < words_per_line; wd++) begin
                        for (int unsigned by = 0; by < data_width / 8; by++) begin
                            if (cmd_i.fill || (wd == cmd_i.word_sel && cmd_i.be[by])) begin
                                data_q[cmd_i.index][w][wd*data_width + by*8 +: 8] <=
                                    cmd_i.wdata[wd*data_width + by*8 +: 8];
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

//--- source/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // ------------------------------------------------
    // address and word sizes
    // ------------------------------------------------
    localparam int unsigned addr_width = 32;
    localparam int unsigned data_width = 64;

    // cache geometry
    localparam int unsigned num_ways       = 2;
    localparam int unsigned num_sets       = 16;
    localparam int unsigned line_width     = 128;
    localparam int unsigned words_per_line = line_width / data_width;

    // address fields: | tag | index | byte offset |
    localparam int unsigned offset_width = $clog2(line_width / 8);
    localparam int unsigned index_width  = $clog2(num_sets);
    localparam int unsigned tag_width    = addr_width - index_width - offset_width;

    typedef logic [addr_width-1:0]   addr_t;
    typedef logic [data_width-1:0]   word_t;
    typedef logic [line_width-1:0]   line_t;
    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [index_width-1:0]  index_t;
    // one bit per way
    typedef logic [num_ways-1:0]     way_vec_t;
    // byte enables of one word
    typedef logic [data_width/8-1:0] be_t;

endpackage

//--- source/cache_ctrl_fsm.sv
`timescale 1ns/1ps

module cache_ctrl_fsm #(
    parameter cache_cfg_pkg::addr_t uncached_limit = 32'h0000_1000
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      bypass_i,
    input  logic                      core_req_valid_i,
    input  cache_req_pkg::core_req_t  core_req_i,
    output cache_req_pkg::core_rsp_t  core_rsp_o,
    output logic                      busy_o,
    // array side
    output logic                      arr_cmd_valid_o,
    output cache_req_pkg::array_cmd_t arr_cmd_o,
    input  logic                      hit_i,
    input  cache_cfg_pkg::way_vec_t   hit_way_i,
    input  cache_cfg_pkg::word_t      hit_word_i,
    input  cache_cfg_pkg::way_vec_t   victim_way_i,
    // memory side
    output logic                      mem_start_o,
    output cache_req_pkg::mem_req_t   mem_cmd_o,
    input  logic                      mem_done_i,
    input  cache_cfg_pkg::line_t      mem_line_i
);

    import cache_cfg_pkg::*;
    import cache_req_pkg::*;

    // lowest address bit that picks the word inside a line
    localparam int unsigned word_lsb = $clog2(data_width / 8);

    ctrl_state_e state_d, state_q;
    core_req_t   req_q;
    // direct: bypassed or below the cacheable range
    logic        direct_d, direct_q;
    logic        accept;

    assign busy_o   = (state_q != idle);
    assign direct_d = bypass_i || (core_req_i.addr < uncached_limit);

    // ------------------------------------------------
    // memory command from the registered request
    // ------------------------------------------------
    // loads fetch the whole line, stores write one word
    assign mem_cmd_o.addr  = req_q.we ?
        {req_q.addr[addr_width-1:word_lsb], {word_lsb{1'b0}}} :
        {req_q.addr[addr_width-1:offset_width], {offset_width{1'b0}}};
    assign mem_cmd_o.we    = req_q.we ? op_write : op_read;
    assign mem_cmd_o.be    = req_q.be;
    assign mem_cmd_o.wdata = req_q.wdata;

    // ------------------------------------------------
    // controller FSM
    // ------------------------------------------------
    always_comb begin
        state_d         = state_q;
        accept          = 1'b0;
        core_rsp_o      = '0;
        mem_start_o     = 1'b0;
        arr_cmd_valid_o = 1'b0;
        // array command defaults to the saved request
        arr_cmd_o.index    = req_q.addr[offset_width +: index_width];
        arr_cmd_o.tag      = req_q.addr[addr_width-1 -: tag_width];
        arr_cmd_o.word_sel = req_q.addr[word_lsb];
        arr_cmd_o.way      = hit_way_i;
        arr_cmd_o.we       = 1'b0;
        arr_cmd_o.fill     = 1'b0;
        arr_cmd_o.be       = req_q.be;
        arr_cmd_o.wdata    = {words_per_line{req_q.wdata}};

        unique case (state_q)
            idle: begin
                if (core_req_valid_i) begin
                    accept         = 1'b1;
                    core_rsp_o.gnt = 1'b1;
                    if (direct_d) begin
                        // no lookup, straight to memory
                        state_d = mem_start;
                    end else begin
                        // read the set of the incoming address
                        arr_cmd_valid_o = 1'b1;
                        arr_cmd_o.index = core_req_i.addr[offset_width +: index_width];
                        state_d         = tag_check;
                    end
                end
            end

            // set contents are valid now
            tag_check: begin
                if (hit_i && !req_q.we) begin
                    core_rsp_o.rvalid = 1'b1;
                    core_rsp_o.rdata  = hit_word_i;
                    state_d           = idle;
                end else if (hit_i) begin
                    state_d = store_write;
                end else begin
                    // load miss refills, store miss only writes memory
                    state_d = mem_start;
                end
            end

            // second array access, merge store bytes into the hit way
            // arrays still show the looked-up set, so hit_way_i holds
            store_write: begin
                arr_cmd_valid_o = 1'b1;
                arr_cmd_o.we    = 1'b1;
                state_d         = mem_start;
            end

            mem_start: begin
                mem_start_o = 1'b1;
                state_d     = mem_wait;
            end

            mem_wait: begin
                if (mem_done_i) begin
                    state_d = idle;
                    if (!req_q.we) begin
                        core_rsp_o.rvalid = 1'b1;
                        core_rsp_o.rdata  =
                            mem_line_i[req_q.addr[word_lsb]*data_width +: data_width];
                        // cached load miss, fill the victim way
                        if (!direct_q) begin
                            arr_cmd_valid_o = 1'b1;
                            arr_cmd_o.we    = 1'b1;
                            arr_cmd_o.fill  = 1'b1;
                            arr_cmd_o.way   = victim_way_i;
                            arr_cmd_o.wdata = mem_line_i;
                        end
                    end
                end
            end

            default: state_d = idle;
        endcase
    end

    // ------------------------------------------------
    // registers
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= idle;
            direct_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                direct_q <= direct_d;
            end
        end
    end

    // request payload, held until the next grant
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= core_req_i;
        end
    end

endmodule

//--- source/cache_req_pkg.sv
package cache_req_pkg;

    import cache_cfg_pkg::*;

    // memory transaction kind
    typedef enum logic {
        op_read,
        op_write
    } mem_op_e;

    // controller states
    typedef enum logic [2:0] {
        idle,
        tag_check,
        store_write,
        mem_start,
        mem_wait
    } ctrl_state_e;

    // ------------------------------------------------
    // core side
    // ------------------------------------------------
    typedef struct packed {
        addr_t addr;
        logic  we;
        be_t   be;
        word_t wdata;
    } core_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } core_rsp_t;

    // memory side, loads carry a line-aligned address
    typedef struct packed {
        addr_t   addr;
        mem_op_e we;
        be_t     be;
        word_t   wdata;
    } mem_req_t;

    // controller to arrays
    // wdata holds a full line on fill, the replicated store word otherwise
    typedef struct packed {
        index_t   index;
        way_vec_t way;
        logic     we;
        logic     word_sel;
        be_t      be;
        line_t    wdata;
        tag_t     tag;
        logic     fill;
    } array_cmd_t;

endpackage

//--- source/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
    parameter cache_cfg_pkg::addr_t uncached_limit = 32'h0000_1000
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     bypass_i,
    input  logic                     core_req_valid_i,
    input  cache_req_pkg::core_req_t core_req_i,
    output cache_req_pkg::core_rsp_t core_rsp_o,
    output logic                     busy_o,
    output logic                     mem_req_o,
    output cache_req_pkg::mem_req_t  mem_cmd_o,
    input  logic                     mem_ack_i,
    input  cache_cfg_pkg::line_t     mem_rdata_i
);

    import cache_cfg_pkg::*;
    import cache_req_pkg::*;

    // controller <-> arrays
    logic       arr_cmd_valid;
    array_cmd_t arr_cmd;
    tag_t       [num_ways-1:0] tags;
    way_vec_t   valid;
    line_t      [num_ways-1:0] lines;
    way_vec_t   victim_way;

    // way selection results
    logic     hit;
    way_vec_t hit_way;
    word_t    hit_word;

    // controller <-> memory port
    logic     mem_start;
    mem_req_t mem_cmd;
    logic     mem_done;
    line_t    mem_line;

    cache_ctrl_fsm #(
        .uncached_limit(uncached_limit)
    ) i_ctrl (
        .clk_i,
        .rst_ni,
        .bypass_i,
        .core_req_valid_i,
        .core_req_i,
        .core_rsp_o,
        .busy_o,
        .arr_cmd_valid_o(arr_cmd_valid),
        .arr_cmd_o      (arr_cmd),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .hit_word_i     (hit_word),
        .victim_way_i   (victim_way),
        .mem_start_o    (mem_start),
        .mem_cmd_o      (mem_cmd),
        .mem_done_i     (mem_done),
        .mem_line_i     (mem_line)
    );

    cache_arrays i_arrays (
        .clk_i,
        .rst_ni,
        .cmd_valid_i (arr_cmd_valid),
        .cmd_i       (arr_cmd),
        .tags_o      (tags),
        .valid_o     (valid),
        .lines_o     (lines),
        .victim_way_o(victim_way)
    );

    // tag and word select follow the registered request
    way_select i_way_select (
        .tags_i    (tags),
        .valid_i   (valid),
        .lines_i   (lines),
        .req_tag_i (arr_cmd.tag),
        .word_sel_i(arr_cmd.word_sel),
        .hit_o     (hit),
        .hit_way_o (hit_way),
        .hit_word_o(hit_word)
    );

    mem_port i_mem_port (
        .clk_i,
        .rst_ni,
        .start_i    (mem_start),
        .cmd_i      (mem_cmd),
        .done_o     (mem_done),
        .line_o     (mem_line),
        .mem_req_o,
        .mem_cmd_o,
        .mem_ack_i,
        .mem_rdata_i
    );

endmodule

//--- source/mem_port.sv
`timescale 1ns/1ps

module mem_port (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    start_i,
    input  cache_req_pkg::mem_req_t cmd_i,
    output logic                    done_o,
    output cache_cfg_pkg::line_t    line_o,
    // four-phase memory interface
    output logic                    mem_req_o,
    output cache_req_pkg::mem_req_t mem_cmd_o,
    input  logic                    mem_ack_i,
    input  cache_cfg_pkg::line_t    mem_rdata_i
);

    import cache_cfg_pkg::*;
    import cache_req_pkg::*;

    typedef enum logic [1:0] {
        mp_idle,
        mp_req,
        mp_release,
        mp_done
    } port_state_e;

    port_state_e state_q;
    mem_req_t    cmd_q;
    line_t       line_q;

    // req is high only in its own phase
    assign mem_req_o = (state_q == mp_req);
    assign mem_cmd_o = cmd_q;
    assign done_o    = (state_q == mp_done);
    assign line_o    = line_q;

    // ------------------------------------------------
    // handshake sequencing
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= mp_idle;
        end else begin
            unique case (state_q)
                mp_idle:    if (start_i) state_q <= mp_req;
                // wait for ack high, then drop req
                mp_req:     if (mem_ack_i) state_q <= mp_release;
                // wait for ack low before reporting done
                mp_release: if (!mem_ack_i) state_q <= mp_done;
                default:    state_q <= mp_idle;
            endcase
        end
    end

    // command and returned line, line held until the next start
    always_ff @(posedge clk_i) begin
        if (state_q == mp_idle && start_i) begin
            cmd_q <= cmd_i;
        end
        if (state_q == mp_req && mem_ack_i) begin
            line_q <= mem_rdata_i;
        end
    end

endmodule

//--- source/way_select.sv
`timescale 1ns/1ps

module way_select (
    input  cache_cfg_pkg::tag_t     [cache_cfg_pkg::num_ways-1:0] tags_i,
    input  cache_cfg_pkg::way_vec_t valid_i,
    input  cache_cfg_pkg::line_t    [cache_cfg_pkg::num_ways-1:0] lines_i,
    input  cache_cfg_pkg::tag_t     req_tag_i,
    input  logic                    word_sel_i,
    output logic                    hit_o,
    output cache_cfg_pkg::way_vec_t hit_way_o,
    output cache_cfg_pkg::word_t    hit_word_o
);

    import cache_cfg_pkg::*;

    // compare every valid way, at most one matches
    always_comb begin
        hit_way_o  = '0;
        hit_word_o = '0;
        for (int unsigned w = 0; w < num_ways; w++) begin
            if (valid_i[w] && (tags_i[w] == req_tag_i)) begin
                hit_way_o[w] = 1'b1;
                // pick the requested word out of the hit line
                hit_word_o   = lines_i[w][word_sel_i*data_width +: data_width];
            end
        end
    end

    assign hit_o = |hit_way_o;

endmodule

//--- verification/tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;

    import cache_cfg_pkg::*;
    import cache_req_pkg::*;

    localparam int    reset_cycles       = 5;
    localparam int    num_requests       = 22;
    localparam int    cycles_per_request = 60;
    localparam addr_t uncached_limit     = 32'h0000_1000;
    localparam word_t fill_pattern       = 64'h5a5a_0000_a5a5_0000;

    logic      clk_i;
    logic      rst_ni;
    logic      bypass;
    logic      core_req_valid;
    core_req_t core_req;
    core_rsp_t core_rsp;
    logic      busy;
    logic      mem_req;
    mem_req_t  mem_cmd;
    logic      mem_ack;
    line_t     mem_rdata;

    // testbench state
    logic  started;
    logic  expect_hit;
    logic  granted;
    word_t exp_rdata;
    // reference image of memory that mirrors every store
    word_t ref_mem [addr_t];

    cache_top #(
        .uncached_limit(uncached_limit)
    ) i_cache_top (
        .clk_i,
        .rst_ni,
        .bypass_i        (bypass),
        .core_req_valid_i(core_req_valid),
        .core_req_i      (core_req),
        .core_rsp_o      (core_rsp),
        .busy_o          (busy),
        .mem_req_o       (mem_req),
        .mem_cmd_o       (mem_cmd),
        .mem_ack_i       (mem_ack),
        .mem_rdata_i     (mem_rdata)
    );

    tb_mem_model i_mem_model (
        .clk_i,
        .req_i  (mem_req),
        .cmd_i  (mem_cmd),
        .ack_o  (mem_ack),
        .rdata_o(mem_rdata)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    // grant seen at the rising edge
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            granted <= 1'b0;
        end else begin
            granted <= core_rsp.gnt;
        end
    end

    // ------------------------------------------------
    // failure reporting
    // ------------------------------------------------
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        $display("** Error: %s = %0h, expected %0h", name, got, exp);
        abort_run();
    endtask

    // ------------------------------------------------
    // reference model
    // ------------------------------------------------
    function automatic addr_t word_addr(input addr_t addr);
        return {addr[addr_width-1:3], 3'b000};
    endfunction

    function automatic word_t ref_read(input addr_t addr);
        word_t result;
        result = {32'h0, word_addr(addr)} ^ fill_pattern;
        if (ref_mem.exists(word_addr(addr))) begin
            result = ref_mem[word_addr(addr)];
        end
        return result;
    endfunction

    task automatic ref_write(input addr_t addr, input be_t be, input word_t wdata);
        word_t w;
        w = ref_read(addr);
        for (int b = 0; b < data_width / 8; b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        ref_mem[word_addr(addr)] = w;
    endtask

    // random word-aligned address well inside the cacheable range
    function automatic addr_t cached_addr();
        return ($urandom() | 32'h0001_0000) & ~32'h7;
    endfunction

    // ------------------------------------------------
    // concurrent checks
    // ------------------------------------------------
    // nothing moves before the first request
    reset_quiet: assert property (@(posedge clk_i)
        !started |-> !(core_rsp.gnt || core_rsp.rvalid || busy || mem_req))
        else fail_value("gnt/rvalid/busy_o/mem_req_o",
                        $sampled({core_rsp.gnt, core_rsp.rvalid, busy, mem_req}), 0);

    rdata_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp.rvalid |-> (core_rsp.rdata == exp_rdata))
        else fail_value("core_rsp_o.rdata", $sampled(core_rsp.rdata), $sampled(exp_rdata));

    // a store is never answered with rvalid
    store_no_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp.rvalid |-> !core_req.we)
        else fail_value("core_rsp_o.rvalid", 1, 0);

    hit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (core_rsp.gnt && expect_hit) |=> core_rsp.rvalid)
        else fail_value("core_rsp_o.rvalid", 0, 1);

    // four-phase rules on the memory side
    req_rise_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(mem_req) |-> !mem_ack)
        else fail_value("mem_ack_i", 1, 0);

    req_fall_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(mem_req) |-> $past(mem_ack))
        else fail_value("mem_ack_i", 0, 1);

    // ------------------------------------------------
    // one core access and the memory transactions it should cause
    // ------------------------------------------------
    task automatic access(input logic we, input addr_t addr, input be_t be,
                          input word_t wdata, input logic hit, input int txns);
        int txns_before;
        int writes_before;
        txns_before   = i_mem_model.txn_count;
        writes_before = i_mem_model.wr_count;
        @(negedge clk_i);
        started        = 1'b1;
        expect_hit     = hit;
        exp_rdata      = ref_read(addr);
        core_req.addr  = addr;
        core_req.we    = we;
        core_req.be    = be;
        core_req.wdata = wdata;
        core_req_valid = 1'b1;
        // hold until granted
        do begin
            @(negedge clk_i);
        end while (!granted);
        core_req_valid = 1'b0;
        expect_hit     = 1'b0;
        if (we) begin
            while (busy) @(negedge clk_i);
            ref_write(addr, be, wdata);
            assert (i_mem_model.wr_count == writes_before + 1)
                else fail_value("write-through count", i_mem_model.wr_count - writes_before, 1);
            assert (i_mem_model.last_wr_addr == word_addr(addr))
                else fail_value("mem_cmd_o.addr", i_mem_model.last_wr_addr, word_addr(addr));
            assert (i_mem_model.last_wr_be == be)
                else fail_value("mem_cmd_o.be", i_mem_model.last_wr_be, be);
            assert (i_mem_model.last_wr_data == wdata)
                else fail_value("mem_cmd_o.wdata", i_mem_model.last_wr_data, wdata);
        end else begin
            while (!core_rsp.rvalid) @(negedge clk_i);
        end
        assert (i_mem_model.txn_count == txns_before + txns)
            else fail_value("memory transactions", i_mem_model.txn_count - txns_before, txns);
    endtask

    // every bypassed or uncached access goes to memory
    task automatic direct_sequence(input addr_t addr);
        access(1'b0, addr, '0, '0, 1'b0, 1);
        access(1'b0, addr, '0, '0, 1'b0, 1);
        access(1'b1, addr, be_t'($urandom()) | 8'h01, {$urandom(), $urandom()}, 1'b0, 1);
        access(1'b0, addr, '0, '0, 1'b0, 1);
    endtask

    // ------------------------------------------------
    // stimulus
    // ------------------------------------------------
    initial begin : stimulus
        addr_t       a;
        addr_t       line_addr [3];
        void'($urandom(32'he627a780));
        rst_ni         = 1'b0;
        bypass         = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        started        = 1'b0;
        expect_hit     = 1'b0;
        exp_rdata      = '0;
        repeat (reset_cycles) @(negedge clk_i);
        rst_ni = 1'b1;
        repeat (2) @(negedge clk_i);

        // load miss then hits on both words of the line
        a = cached_addr();
        access(1'b0, a, '0, '0, 1'b0, 1);
        access(1'b0, a, '0, '0, 1'b1, 0);
        access(1'b0, a ^ 32'h8, '0, '0, 1'b1, 0);

        // a store hit merges into the line and a store miss only writes memory
        a = cached_addr();
        access(1'b0, a, '0, '0, 1'b0, 1);
        access(1'b1, a, be_t'($urandom()) | 8'h01, {$urandom(), $urandom()}, 1'b0, 1);
        access(1'b0, a, '0, '0, 1'b1, 0);
        a = cached_addr();
        access(1'b1, a, be_t'($urandom()) | 8'h80, {$urandom(), $urandom()}, 1'b0, 1);
        access(1'b0, a, '0, '0, 1'b0, 1);

        // three tags in one set overflow the two ways
        a = cached_addr();
        for (int k = 0; k < 3; k++) begin
            line_addr[k] = a + ((k + 1) << 8);
            access(1'b0, line_addr[k], '0, '0, 1'b0, 1);
        end
        // round robin put the third line over the first one
        access(1'b0, line_addr[2], '0, '0, 1'b1, 0);
        access(1'b0, line_addr[1], '0, '0, 1'b1, 0);
        access(1'b0, line_addr[0], '0, '0, 1'b0, 1);

        bypass = 1'b1;
        direct_sequence(cached_addr());
        bypass = 1'b0;
        direct_sequence(($urandom() & (uncached_limit - 1)) & ~32'h7);

        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        repeat (reset_cycles + cycles_per_request * num_requests) @(posedge clk_i);
        $display("timeout: the tests did not finish in the allowed time");
        abort_run();
    end

endmodule

//--- verification/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                    clk_i,
    input  logic                    req_i,
    input  cache_req_pkg::mem_req_t cmd_i,
    output logic                    ack_o,
    output cache_cfg_pkg::line_t    rdata_o
);

    import cache_cfg_pkg::*;
    import cache_req_pkg::*;

    // untouched words read back as their address xor this
    localparam word_t fill_pattern = 64'h5a5a_0000_a5a5_0000;

    // sparse storage, keyed by word-aligned byte address
    word_t       mem_q [addr_t];
    int unsigned txn_count;
    // write log, last write-through seen
    int unsigned wr_count;
    addr_t       last_wr_addr;
    be_t         last_wr_be;
    word_t       last_wr_data;

    function automatic word_t read_word(input addr_t addr);
        word_t result;
        result = {32'h0, addr} ^ fill_pattern;
        if (mem_q.exists(addr)) begin
            result = mem_q[addr];
        end
        return result;
    endfunction

    // apply one command, reads return the whole line
    task automatic serve_command();
        addr_t a;
        word_t w;
        a = {cmd_i.addr[addr_width-1:3], 3'b000};
        if (cmd_i.we == op_write) begin
            w = read_word(a);
            for (int b = 0; b < data_width / 8; b++) begin
                if (cmd_i.be[b]) begin
                    w[b*8 +: 8] = cmd_i.wdata[b*8 +: 8];
                end
            end
            mem_q[a]     = w;
            wr_count     = wr_count + 1;
            last_wr_addr = a;
            last_wr_be   = cmd_i.be;
            last_wr_data = cmd_i.wdata;
        end else begin
            // word 0 sits in the low half of the line
            rdata_o = {read_word(a + 32'd8), read_word(a)};
        end
        txn_count = txn_count + 1;
    endtask

    // ------------------------------------------------
    // four-phase responder, driven on the falling edge
    // ------------------------------------------------
    initial begin : handshake
        int unsigned delay;
        ack_o     = 1'b0;
        rdata_o   = '0;
        txn_count = 0;
        wr_count  = 0;
        forever begin
            @(negedge clk_i);
            if (req_i) begin
                // random answer time of 1 to 4 cycles
                delay = $urandom_range(4, 1);
                repeat (delay) @(negedge clk_i);
                serve_command();
                ack_o = 1'b1;
                // hold ack until req is released
                do begin
                    @(negedge clk_i);
                end while (req_i);
                ack_o = 1'b0;
            end
        end
    end

endmodule
